/* nes_consts.svh */
// ================================================
// NES loader constants
// Header magic words, cartridge memory map,
// download filetype codes and reset tail length
// ================================================
`ifndef NES_CONSTS_SVH
`define NES_CONSTS_SVH

// First four header bytes, byte 0 in the top byte
`define NES_MAGIC_INES 32'h4E45531A
`define NES_MAGIC_FDS 32'h4644531A

// Cartridge memory map
`define NES_ADDR_W 22
`define NES_ADDR_PRG 22'h000000
`define NES_ADDR_CHR 22'h200000
`define NES_ADDR_FDS_SKIP 22'h010010 // Disk image with a 16 byte header
`define NES_ADDR_BIOS_SKIP 22'h000010
`define NES_ADDR_FDS_RAW 22'h010020 // Disk image without header

// Download index codes
`define NES_FILETYPE_BIOS 8'd2
`define NES_FILETYPE_FDS 8'd3

// Console reset hold after a download, in clk cycles
`define NES_RESET_TAIL 8'd255

`endif

/* nes_pkg.sv */
// ================================================
// NES loader types
// Header, mapper flags, memory write, pad and FSM
// ================================================
`default_nettype none

`include "nes_consts.svh"

package nes_pkg;

	// 16 byte iNES header, byte 0 in the top bits
	typedef struct packed {
		logic [31:0] magic;
		logic [7:0] prg_pages; // 16 KB units
		logic [7:0] chr_pages; // 8 KB units, 0 means CHR RAM
		logic [7:0] flags6;
		logic [7:0] flags7;
		logic [63:0] ext; // Bytes 8 to 15
	} ines_header_t;

	// Word handed to the mappers
	typedef struct packed {
		logic [6:0] pad;
		logic [7:0] ines2_mapper;
		logic four_screen;
		logic chr_ram;
		logic mirroring;
		logic [2:0] chr_size;
		logic [2:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic valid;
		logic [`NES_ADDR_W-1:0] addr;
		logic [7:0] data;
	} mem_wr_t;

	typedef enum logic [1:0] {KIND_INES, KIND_FDS, KIND_OTHER} header_kind_t;

	typedef enum logic [2:0] {LD_HEADER, LD_PRG, LD_CHR, LD_FAIL, LD_RAW} loader_state_t;

	typedef struct packed {
		logic [7:0] raw; // Joystick bits as delivered by the host
	} pad_t;

endpackage

`default_nettype wire

/* ines_header_decode.sv */
// ================================================
// iNES header decode
// Classifies the file and builds the mapper flags
// ================================================
`default_nettype none

`include "nes_consts.svh"

module ines_header_decode (
	input wire nes_pkg::ines_header_t header,
	input wire invert_mirroring,
	output nes_pkg::header_kind_t kind,
	output logic [`NES_ADDR_W-1:0] prg_bytes,
	output logic [`NES_ADDR_W-1:0] chr_bytes,
	output nes_pkg::mapper_flags_t flags
);

	logic is_nes20;
	logic is_dirty;

	// Log2 style size code, saturating at 7 above 64 pages
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		if (pages <= 8'd1) return 3'd0;
		else if (pages <= 8'd2) return 3'd1;
		else if (pages <= 8'd4) return 3'd2;
		else if (pages <= 8'd8) return 3'd3;
		else if (pages <= 8'd16) return 3'd4;
		else if (pages <= 8'd32) return 3'd5;
		else if (pages <= 8'd64) return 3'd6;
		else return 3'd7;
	endfunction

	always_comb begin
		if (header.magic == `NES_MAGIC_INES)
			kind = nes_pkg::KIND_INES;
		else if (header.magic == `NES_MAGIC_FDS)
			kind = nes_pkg::KIND_FDS;
		else
			kind = nes_pkg::KIND_OTHER;
	end

	assign is_nes20 = (header.flags7[3:2] == 2'b10);
	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 && (header.ext != 64'd0);

	assign prg_bytes = {header.prg_pages, 14'd0};
	assign chr_bytes = {1'b0, header.chr_pages, 13'd0};

	always_comb begin
		flags.pad = 7'd0;
		flags.ines2_mapper = is_nes20 ? header.ext[63:56] : 8'h00; // Byte 8
		flags.four_screen = header.flags6[3];
		flags.chr_ram = (header.chr_pages == 8'd0);
		flags.mirroring = header.flags6[0] ^ invert_mirroring;
		flags.chr_size = size_code(header.chr_pages);
		flags.prg_size = size_code(header.prg_pages);
		flags.mapper = {is_dirty ? 4'h0 : header.flags7[7:4], header.flags6[7:4]};
	end

endmodule

`default_nettype wire

/* game_loader.sv */
// ================================================
// Game loader
// Parses the download stream, places each byte in
// cartridge memory and latches the mapper flags
// ================================================
`default_nettype none

`include "nes_consts.svh"

module game_loader (
	input wire clk,
	input wire reset,
	input wire loader_reset,
	input wire downloading,
	input wire [7:0] filetype,
	input wire [7:0] dl_byte,
	input wire dl_strobe,
	input wire invert_mirroring,
	output nes_pkg::mem_wr_t loader_wr,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic done,
	output logic fail
);

	nes_pkg::loader_state_t state;
	nes_pkg::ines_header_t hdr;
	nes_pkg::header_kind_t kind;
	nes_pkg::mapper_flags_t dec_flags;
	logic [`NES_ADDR_W-1:0] prg_bytes;
	logic [`NES_ADDR_W-1:0] chr_bytes;
	logic [`NES_ADDR_W-1:0] addr;
	logic [`NES_ADDR_W-1:0] bytes_left;
	logic [3:0] byte_cnt;
	logic [3:0] hdr_sel;
	logic rom_phase;
	logic stream_phase;

	ines_header_decode decode0 (
		.header(hdr),
		.invert_mirroring(invert_mirroring),
		.kind(kind),
		.prg_bytes(prg_bytes),
		.chr_bytes(chr_bytes),
		.flags(dec_flags)
	);

	assign hdr_sel = 4'd15 - byte_cnt; // Byte 0 lands in the top of the struct

	assign rom_phase = (state == nes_pkg::LD_PRG || state == nes_pkg::LD_CHR) && bytes_left != '0;
	assign stream_phase = downloading && (state == nes_pkg::LD_HEADER || state == nes_pkg::LD_RAW);

	assign loader_wr.valid = dl_strobe && (rom_phase || stream_phase);
	assign loader_wr.addr = addr;
	assign loader_wr.data = dl_byte;

	always_ff @(posedge clk) begin
		if (reset || loader_reset) begin
			state <= nes_pkg::LD_HEADER;
			done <= 1'b0;
			byte_cnt <= 4'd0;
			// Disk images with a header start 16 bytes early so the payload lands at the skip base
			addr <= (filetype == `NES_FILETYPE_FDS) ? `NES_ADDR_FDS_SKIP - 22'h10 : 22'h0;
			if (reset)
				fail <= 1'b0; // A failed load stays visible until the next header
		end else begin
			case (state)
				nes_pkg::LD_HEADER: if (dl_strobe) begin
					fail <= 1'b0;
					byte_cnt <= byte_cnt + 4'd1;
					addr <= addr + 1'b1;
					hdr[{hdr_sel, 3'b000} +: 8] <= dl_byte;
					if (byte_cnt == 4'd15) begin
						if (kind == nes_pkg::KIND_INES && !hdr.flags6[2]) begin // No trainer support
							state <= nes_pkg::LD_PRG;
							addr <= `NES_ADDR_PRG;
							bytes_left <= prg_bytes;
						end else if (kind == nes_pkg::KIND_FDS) begin
							state <= nes_pkg::LD_RAW;
							addr <= `NES_ADDR_FDS_SKIP;
						end else if (filetype == `NES_FILETYPE_BIOS) begin
							state <= nes_pkg::LD_RAW;
							addr <= `NES_ADDR_BIOS_SKIP;
						end else if (filetype == `NES_FILETYPE_FDS) begin
							state <= nes_pkg::LD_RAW;
							addr <= `NES_ADDR_FDS_RAW;
						end else begin
							state <= nes_pkg::LD_FAIL;
						end
					end
				end
				nes_pkg::LD_PRG, nes_pkg::LD_CHR: begin
					if (bytes_left != '0) begin
						if (dl_strobe) begin
							bytes_left <= bytes_left - 1'b1;
							addr <= addr + 1'b1;
						end
					end else if (state == nes_pkg::LD_PRG) begin
						state <= nes_pkg::LD_CHR;
						addr <= `NES_ADDR_CHR;
						bytes_left <= chr_bytes;
					end else begin
						done <= 1'b1;
					end
				end
				nes_pkg::LD_RAW: begin
					if (downloading) begin
						if (dl_strobe)
							addr <= addr + 1'b1;
					end else begin
						// Stand-in header so the FDS mapper gets sane flags
						hdr.prg_pages <= 8'hFF;
						hdr.chr_pages <= 8'h00;
						hdr.flags6 <= 8'h40;
						hdr.flags7 <= 8'h10;
						hdr.ext <= 64'd0;
						done <= 1'b1;
					end
				end
				default: begin // LD_FAIL
					done <= 1'b1;
					fail <= 1'b1;
				end
			endcase
		end
	end

	// Flags survive the loader reset that follows each download
	always_ff @(posedge clk) begin
		if (reset)
			mapper_flags <= '0;
		else if (done)
			mapper_flags <= dec_flags;
	end

endmodule

`default_nettype wire

/* mem_write_stager.sv */
// ================================================
// Memory write stager
// Holds one loader write and issues it in the
// next console clock-enable slot
// ================================================
`default_nettype none

module mem_write_stager (
	input wire clk,
	input wire reset,
	input wire nes_pkg::mem_wr_t loader_wr,
	input wire [1:0] ce_phase,
	output nes_pkg::mem_wr_t mem_wr
);

	logic pending;
	logic slot;
	logic [21:0] addr_q;
	logic [7:0] data_q;

	assign slot = (ce_phase == 2'd3);

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end else if (loader_wr.valid) begin
			pending <= 1'b1; // Newer write replaces anything still waiting
		end else if (slot) begin
			pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (loader_wr.valid) begin
			addr_q <= loader_wr.addr;
			data_q <= loader_wr.data;
		end
	end

	// Single cycle strobe inside the slot
	assign mem_wr.valid = pending && slot;
	assign mem_wr.addr = addr_q;
	assign mem_wr.data = data_q;

endmodule

`default_nettype wire

/* reset_sequencer.sv */
// ================================================
// Reset sequencer
// Console reset causes, loader release window and
// the one-in-four clock-enable counter
// ================================================
`default_nettype none

`include "nes_consts.svh"

module reset_sequencer (
	input wire clk,
	input wire reset,
	input wire downloading,
	input wire loader_fail,
	output logic [1:0] ce_phase,
	output logic run_ce,
	output logic loader_reset,
	output logic nes_reset
);

	logic init_reset;
	logic [7:0] tail_cnt;
	logic tail_active;

	// Console stays parked until a game has been sent at least once
	always_ff @(posedge clk) begin
		if (reset)
			init_reset <= 1'b1;
		else if (downloading)
			init_reset <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset)
			tail_cnt <= 8'd0;
		else if (downloading)
			tail_cnt <= `NES_RESET_TAIL;
		else if (tail_active)
			tail_cnt <= tail_cnt - 8'd1;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ce_phase <= 2'd0;
		else
			ce_phase <= ce_phase + 2'd1;
	end

	assign tail_active = (tail_cnt != 8'd0);
	assign run_ce = (ce_phase == 2'd3); // Keeps running through reset so the core can settle
	assign loader_reset = !tail_active;
	assign nes_reset = init_reset || tail_active || loader_fail;

endmodule

`default_nettype wire

/* joypad_serializer.sv */
// ================================================
// Joypad serializer
// Latches pads and multitap signature per port and
// shifts them out on the port clocks
// ================================================
`default_nettype none

module joypad_serializer (
	input wire clk,
	input wire nes_reset,
	input wire multitap_en,
	input wire joy_swap,
	input wire nes_pkg::pad_t joy_a,
	input wire nes_pkg::pad_t joy_b,
	input wire nes_pkg::pad_t joy_c,
	input wire nes_pkg::pad_t joy_d,
	input wire joypad_strobe,
	input wire [1:0] joypad_clock,
	output logic [1:0] joypad_data
);

	logic [7:0] pad_a;
	logic [7:0] pad_b;
	logic [7:0] pad_c;
	logic [7:0] pad_d;
	logic [23:0] latch_val [2];
	logic [23:0] port_q [2];
	logic [1:0] last_clock;

	// Host button order to console shift order, blanked during reset
	function automatic logic [7:0] reorder(input nes_pkg::pad_t pad, input logic blank);
		logic [7:0] r;
		r = pad.raw;
		if (blank)
			return 8'd0;
		return {r[0], r[1], r[2], r[3], r[7], r[6], r[5], r[4]};
	endfunction

	assign pad_a = reorder(joy_a, nes_reset);
	assign pad_b = reorder(joy_b, nes_reset);
	assign pad_c = reorder(joy_c, nes_reset);
	assign pad_d = reorder(joy_d, nes_reset);

	// Upper 16 bits carry the four-score block when the tap is on
	assign latch_val[0] = {multitap_en ? {8'h08, pad_c} : 16'h0000, joy_swap ? pad_b : pad_a};
	assign latch_val[1] = {multitap_en ? {8'h04, pad_d} : 16'h0000, joy_swap ? pad_a : pad_b};

	always_ff @(posedge clk) begin
		if (nes_reset) begin
			port_q[0] <= 24'd0;
			port_q[1] <= 24'd0;
			last_clock <= 2'b00;
		end else begin
			for (int n = 0; n < 2; n++) begin
				if (joypad_strobe)
					port_q[n] <= latch_val[n];
				if (!joypad_clock[n] && last_clock[n]) // Falling edge wins over the latch
					port_q[n] <= {1'b0, port_q[n][23:1]};
			end
			last_clock <= joypad_clock;
		end
	end

	assign joypad_data = {port_q[1][0], port_q[0][0]};

endmodule

`default_nettype wire

/* nes_loader_top.sv */
// ================================================
// NES loader top
// Cartridge download path, console reset control
// and controller port serializer
// ================================================
`default_nettype none

module nes_loader_top (
	input wire clk,
	input wire reset,
	input wire downloading,
	input wire [7:0] filetype,
	input wire [7:0] dl_byte,
	input wire dl_strobe,
	input wire invert_mirroring,
	input wire multitap_en,
	input wire joy_swap,
	input wire nes_pkg::pad_t joy_a,
	input wire nes_pkg::pad_t joy_b,
	input wire nes_pkg::pad_t joy_c,
	input wire nes_pkg::pad_t joy_d,
	input wire joypad_strobe,
	input wire [1:0] joypad_clock,
	output nes_pkg::mem_wr_t mem_wr,
	output nes_pkg::mapper_flags_t mapper_flags,
	output logic loader_done,
	output logic loader_fail,
	output logic nes_reset,
	output logic run_ce,
	output logic [1:0] joypad_data
);

	logic [1:0] ce_phase;
	logic loader_reset;
	nes_pkg::mem_wr_t loader_wr;

	reset_sequencer rst_seq0 (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.loader_fail(loader_fail),
		.ce_phase(ce_phase),
		.run_ce(run_ce),
		.loader_reset(loader_reset),
		.nes_reset(nes_reset)
	);

	game_loader loader0 (
		.clk(clk),
		.reset(reset),
		.loader_reset(loader_reset),
		.downloading(downloading),
		.filetype(filetype),
		.dl_byte(dl_byte),
		.dl_strobe(dl_strobe),
		.invert_mirroring(invert_mirroring),
		.loader_wr(loader_wr),
		.mapper_flags(mapper_flags),
		.done(loader_done),
		.fail(loader_fail)
	);

	// Loader writes go out on the console's memory slot
	mem_write_stager stager0 (
		.clk(clk),
		.reset(reset),
		.loader_wr(loader_wr),
		.ce_phase(ce_phase),
		.mem_wr(mem_wr)
	);

	joypad_serializer joy0 (
		.clk(clk),
		.nes_reset(nes_reset),
		.multitap_en(multitap_en),
		.joy_swap(joy_swap),
		.joy_a(joy_a),
		.joy_b(joy_b),
		.joy_c(joy_c),
		.joy_d(joy_d),
		.joypad_strobe(joypad_strobe),
		.joypad_clock(joypad_clock),
		.joypad_data(joypad_data)
	);

endmodule

`default_nettype wire

/* tb_nes_loader.sv */
// ================================================
// NES loader testbench
// Download, console reset and joypad checks against
// a predicted memory write stream
// ================================================
`default_nettype none

`include "nes_consts.svh"

module tb_nes_loader;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int PRG_PAGES = 1;
	localparam int CHR_PAGES = 1;
	localparam int FDS_RAW_BYTES = 48;
	localparam int TOTAL_BYTES = 16 + PRG_PAGES * 16384 + CHR_PAGES * 8192
		+ 16 + 16 + FDS_RAW_BYTES;
	localparam int CYCLE_LIMIT = TOTAL_BYTES * 6 + 4000;
	localparam logic [31:0] RAND_SEED = 32'h0a851dc9;

	typedef struct packed {
		logic [`NES_ADDR_W-1:0] addr;
		logic [7:0] data;
		logic [31:0] cycle; // Cycle in which the DUT samples the strobe
	} wr_expect_t;

	logic clk;
	logic reset;
	logic downloading;
	logic [7:0] filetype;
	logic [7:0] dl_byte;
	logic dl_strobe;
	logic invert_mirroring;
	logic multitap_en;
	logic joy_swap;
	nes_pkg::pad_t joy_a;
	nes_pkg::pad_t joy_b;
	nes_pkg::pad_t joy_c;
	nes_pkg::pad_t joy_d;
	logic joypad_strobe;
	logic [1:0] joypad_clock;
	nes_pkg::mem_wr_t mem_wr;
	nes_pkg::mapper_flags_t mapper_flags;
	logic loader_done;
	logic loader_fail;
	logic nes_reset;
	logic run_ce;
	logic [1:0] joypad_data;

	wr_expect_t wr_model [$];
	wr_expect_t head;
	nes_pkg::mapper_flags_t exp_flags = '0;
	nes_pkg::mapper_flags_t flags_prev;
	logic flags_check_en = 1'b0;
	logic dl_started;
	int unsigned cyc = 0;
	string test_name = "reset";

	nes_loader_top dut0 (
		.clk(clk),
		.reset(reset),
		.downloading(downloading),
		.filetype(filetype),
		.dl_byte(dl_byte),
		.dl_strobe(dl_strobe),
		.invert_mirroring(invert_mirroring),
		.multitap_en(multitap_en),
		.joy_swap(joy_swap),
		.joy_a(joy_a),
		.joy_b(joy_b),
		.joy_c(joy_c),
		.joy_d(joy_d),
		.joypad_strobe(joypad_strobe),
		.joypad_clock(joypad_clock),
		.mem_wr(mem_wr),
		.mapper_flags(mapper_flags),
		.loader_done(loader_done),
		.loader_fail(loader_fail),
		.nes_reset(nes_reset),
		.run_ce(run_ce),
		.joypad_data(joypad_data)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at cycle %0d", cyc);
	endtask

	task automatic fail_check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		stop_with_failure();
	endtask

	// Pages to size code, one step per doubling, capped at 7
	function automatic logic [2:0] pages_to_code(input logic [7:0] pages);
		int limit;
		logic [2:0] code;
		limit = 1;
		code = 3'd0;
		while (pages > limit && code != 3'd7) begin
			limit = limit * 2;
			code = code + 3'd1;
		end
		return code;
	endfunction

	function automatic nes_pkg::mapper_flags_t expected_flags(input logic [7:0] prg,
		input logic [7:0] chr, input logic [7:0] f6, input logic [7:0] f7,
		input logic [63:0] ext, input logic inv);
		nes_pkg::mapper_flags_t f;
		logic nes2;
		nes2 = (f7[3:2] == 2'b10);
		f = '0;
		f.ines2_mapper = nes2 ? ext[63:56] : 8'h00;
		f.four_screen = f6[3];
		f.chr_ram = (chr == 8'h00);
		f.mirroring = f6[0] ^ inv;
		f.chr_size = pages_to_code(chr);
		f.prg_size = pages_to_code(prg);
		f.mapper[7:4] = (!nes2 && ext != 64'd0) ? 4'h0 : f7[7:4];
		f.mapper[3:0] = f6[7:4];
		return f;
	endfunction

	// Button order as the console shifts it
	function automatic logic [7:0] console_order(input logic [7:0] raw);
		logic [7:0] r;
		for (int k = 0; k < 4; k++) begin
			r[7 - k] = raw[k];
			r[3 - k] = raw[7 - k];
		end
		return r;
	endfunction

	// Timeout and the memory write comparison against the model queue
	always @(posedge clk) begin
		cyc <= cyc + 1;
		flags_prev <= mapper_flags;
		if (cyc >= CYCLE_LIMIT) begin
			$display("Timeout: %0d cycles used, test %s did not finish", cyc, test_name);
			stop_with_failure();
		end else if (!reset && mem_wr.valid) begin
			if (wr_model.size() == 0) begin
				$display("Memory write to %h in test %s with none predicted",
					mem_wr.addr, test_name);
				stop_with_failure();
			end else begin
				head = wr_model.pop_front();
				write_addr: assert (mem_wr.addr == head.addr)
					else fail_check({test_name, " write addr"}, head.addr, mem_wr.addr);
				write_data: assert (mem_wr.data == head.data)
					else fail_check({test_name, " write data"}, head.data, mem_wr.data);
				write_delay: assert (cyc - head.cycle >= 1 && cyc - head.cycle <= 4)
					else fail_check({test_name, " write delay"}, 4, cyc - head.cycle);
			end
		end
	end

	reset_idle: assert property (@(posedge clk) $fell(reset) |->
		!mem_wr.valid && !loader_done && !loader_fail && joypad_data == 2'b00 && nes_reset)
		else fail_check("reset_idle", 6'b000001,
			{mem_wr.valid, loader_done, loader_fail, joypad_data, nes_reset});
	init_hold: assert property (@(posedge clk) disable iff (reset) !dl_started |-> nes_reset)
		else fail_check("init_hold", 1, nes_reset);
	write_slot: assert property (@(posedge clk) disable iff (reset) mem_wr.valid |-> run_ce)
		else fail_check("write_slot", 1, run_ce);
	fail_hold: assert property (@(posedge clk) disable iff (reset) loader_fail |-> nes_reset)
		else fail_check("fail_hold", 1, nes_reset);
	flags_value: assert property (@(posedge clk) disable iff (reset)
		loader_done && flags_check_en |=> mapper_flags == exp_flags)
		else fail_check({test_name, " flags"}, exp_flags, mapper_flags);
	flags_keep: assert property (@(posedge clk) disable iff (reset)
		!loader_done |=> mapper_flags == flags_prev)
		else fail_check("flags_keep", flags_prev, mapper_flags);

	task automatic send_byte(input logic [7:0] b, input logic [`NES_ADDR_W-1:0] addr);
		@(posedge clk);
		dl_byte <= b;
		dl_strobe <= 1'b1;
		wr_model.push_back('{addr: addr, data: b, cycle: cyc + 1});
		@(posedge clk);
		dl_strobe <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic send_header(input logic [127:0] hdr, input logic [`NES_ADDR_W-1:0] base);
		for (int i = 0; i < 16; i++)
			send_byte(hdr[127 - 8 * i -: 8], base + 22'(i));
	endtask

	task automatic start_download(input logic [7:0] ft, input logic inv);
		@(posedge clk);
		filetype <= ft;
		invert_mirroring <= inv;
		@(posedge clk);
		downloading <= 1'b1;
		dl_started <= 1'b1;
		repeat (3) @(posedge clk); // Loader leaves reset one cycle after downloading
	endtask

	task automatic end_download();
		@(posedge clk);
		downloading <= 1'b0;
	endtask

	task automatic check_drained();
		repeat (6) @(posedge clk);
		drained: assert (wr_model.size() == 0)
			else fail_check({test_name, " writes missing"}, 0, wr_model.size());
	endtask

	task automatic run_ines_load();
		test_name = "ines_load";
		exp_flags = expected_flags(8'(PRG_PAGES), 8'(CHR_PAGES), 8'h21, 8'h00, 64'd0, 1'b0);
		flags_check_en = 1'b1;
		start_download(8'd0, 1'b0);
		send_header({`NES_MAGIC_INES, 8'(PRG_PAGES), 8'(CHR_PAGES), 8'h21, 8'h00, 64'd0},
			22'h0);
		for (int i = 0; i < PRG_PAGES * 16384; i++)
			send_byte(8'($urandom), `NES_ADDR_PRG + 22'(i));
		for (int i = 0; i < CHR_PAGES * 8192; i++)
			send_byte(8'($urandom), `NES_ADDR_CHR + 22'(i));
		while (!loader_done)
			@(posedge clk);
		check_drained();
	endtask

	task automatic check_reset_tail();
		int n;
		test_name = "reset_tail";
		end_download();
		@(posedge clk);
		n = 1;
		while (nes_reset) begin
			@(posedge clk);
			n++;
		end
		tail_len: assert (n == `NES_RESET_TAIL + 1)
			else fail_check(test_name, `NES_RESET_TAIL + 1, n);
		repeat (4) @(posedge clk);
		flags_after: assert (mapper_flags == exp_flags)
			else fail_check({test_name, " flags"}, exp_flags, mapper_flags);
	endtask

	task automatic run_bad_magic();
		test_name = "bad_magic";
		flags_check_en = 1'b0;
		start_download(8'd0, 1'b0);
		send_header({32'h554E4B1A, 96'd0}, 22'h0);
		while (!loader_fail)
			@(posedge clk);
		check_drained();
		end_download();
		while (loader_done) // Done clears when the loader goes back into reset
			@(posedge clk);
		repeat (4) @(posedge clk);
		fail_state: assert (loader_fail && nes_reset)
			else fail_check(test_name, 2'b11, {loader_fail, nes_reset});
	endtask

	task automatic run_fds_load();
		test_name = "fds_load";
		exp_flags = expected_flags(8'hFF, 8'h00, 8'h40, 8'h10, 64'd0, 1'b1);
		flags_check_en = 1'b1;
		start_download(`NES_FILETYPE_FDS, 1'b1);
		send_header({`NES_MAGIC_FDS, $urandom, $urandom, $urandom},
			`NES_ADDR_FDS_SKIP - 22'h10);
		for (int i = 0; i < FDS_RAW_BYTES; i++)
			send_byte(8'($urandom), `NES_ADDR_FDS_SKIP + 22'(i));
		check_drained();
		end_download();
		while (!loader_done)
			@(posedge clk);
		while (nes_reset)
			@(posedge clk);
	endtask

	task automatic run_joypad_rounds();
		logic [23:0] exp_port [2];
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
		logic [7:0] d;
		logic [1:0] exp_bits;
		test_name = "joypad";
		for (int mt = 1; mt >= 0; mt--) begin
			for (int sw = 1; sw >= 0; sw--) begin
				a = 8'($urandom);
				b = 8'($urandom);
				c = 8'($urandom);
				d = 8'($urandom);
				@(posedge clk);
				joy_a <= a;
				joy_b <= b;
				joy_c <= c;
				joy_d <= d;
				multitap_en <= (mt != 0);
				joy_swap <= (sw != 0);
				@(posedge clk);
				joypad_strobe <= 1'b1;
				@(posedge clk);
				joypad_strobe <= 1'b0;
				exp_port[0] = {(mt != 0) ? {8'h08, console_order(c)} : 16'h0000,
					console_order((sw != 0) ? b : a)};
				exp_port[1] = {(mt != 0) ? {8'h04, console_order(d)} : 16'h0000,
					console_order((sw != 0) ? a : b)};
				@(posedge clk);
				for (int i = 0; i < 26; i++) begin
					exp_bits = (i < 24) ? {exp_port[1][i], exp_port[0][i]} : 2'b00;
					pad_bit: assert (joypad_data == exp_bits)
						else fail_check($sformatf("%s bit %0d", test_name, i),
							exp_bits, joypad_data);
					joypad_clock <= 2'b11;
					@(posedge clk);
					joypad_clock <= 2'b00;
					repeat (2) @(posedge clk); // Shift lands on the second edge
				end
			end
		end
	endtask

	initial begin
		reset <= 1'b1;
		downloading <= 1'b0;
		filetype <= 8'd0;
		dl_byte <= 8'd0;
		dl_strobe <= 1'b0;
		invert_mirroring <= 1'b0;
		multitap_en <= 1'b0;
		joy_swap <= 1'b0;
		joy_a <= '0;
		joy_b <= '0;
		joy_c <= '0;
		joy_d <= '0;
		joypad_strobe <= 1'b0;
		joypad_clock <= 2'b00;
		dl_started <= 1'b0;
		void'($urandom(RAND_SEED));
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		repeat (20) @(posedge clk);
		run_ines_load();
		check_reset_tail();
		run_bad_magic();
		run_fds_load();
		run_joypad_rounds();
		repeat (4) @(posedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
nes_pkg.sv
ines_header_decode.sv
game_loader.sv
mem_write_stager.sv
reset_sequencer.sv
joypad_serializer.sv
nes_loader_top.sv
tb_nes_loader.sv

/* run_sim.sh */
#!/bin/sh
# Builds the NES loader testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_nes_loader \
	--Mdir obj_dir -o sim_nes_loader &&
./obj_dir/sim_nes_loader > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log 2>/dev/null && echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
